//--- sim.f
source/axi_pkg.sv
source/bus_ctrl.sv
source/mem_slave.sv
source/led_slave.sv
source/status_display.sv
source/axi_sys_top.sv
testbench/tb_axi_sys_top_asserts.sv
testbench/tb_axi_sys_top.sv

//--- Bender.yml
package:
  name: axi_sys

sources:
  - files:
      - source/axi_pkg.sv
      - source/bus_ctrl.sv
      - source/mem_slave.sv
      - source/led_slave.sv
      - source/status_display.sv
      - source/axi_sys_top.sv
  - target: test
    files:
      - testbench/tb_axi_sys_top_asserts.sv
      - testbench/tb_axi_sys_top.sv

//--- testbench/tb_axi_sys_top.sv
`timescale 1ns/1ps

module tb_axi_sys_top;
    import axi_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int N_WR      = 32;
    localparam int N_ALIAS   = 16;
    localparam int N_LED     = 16;
    localparam int N_DEC     = 16;
    localparam int N_MIX     = 24;
    localparam int N_BTN     = 16;
    localparam int N_TXN     = 3 * N_WR + N_ALIAS + N_LED + N_DEC + N_MIX;
    localparam int TIMEOUT   = N_TXN * 20 + 200;

    logic       clk = 1'b0;
    logic       rst_n;
    bus_req_t   req;
    logic       req_valid;
    logic       req_ready;
    bus_rsp_t   rsp;
    logic       rsp_valid;
    logic       rsp_ready;
    logic [1:0] btn;
    logic [7:0] led8;
    logic [3:0] led4;

    logic [31:0] lfsr   = 32'he99b;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    // reference model state
    data_t      m_mem [int];
    logic [7:0] m_led  = 8'd0;
    logic [7:0] m_txn  = 8'd0;
    logic [7:0] m_err  = 8'd0;
    resp_t      m_last = RESP_OKAY;
    page_t      m_page = '0;
    addr_t      wr_addrs [$];

    axi_sys_top #(.MEM_WORDS(MEM_WORDS)) axi_sys_top_i (.*);

    bind bus_ctrl tb_axi_sys_top_asserts bus_ctrl_asserts_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic bus_req_t rand_req(input region_t region, input logic write);
        bus_req_t r;
        r.write       = write;
        r.addr[27:0]  = 28'(rand_bits(28));
        r.addr[31:28] = region;
        r.addr[1:0]   = 2'b00; // word aligned
        r.wdata       = rand_bits(32);
        r.strb        = strb_t'(rand_bits(4));
        return r;
    endfunction

    function automatic void model_access(input bus_req_t r, output bus_rsp_t exp);
        int    idx;
        data_t w;
        exp.rdata = '0;
        exp.resp  = RESP_OKAY;
        idx = int'(r.addr[31:2] % MEM_WORDS);
        if (r.addr[31:28] == REGION_MEM) begin
            w = m_mem.exists(idx) ? m_mem[idx] : 'x;
            for (int b = 0; b < 4; b++) begin
                if (r.write && r.strb[b]) w[8*b +: 8] = r.wdata[8*b +: 8];
            end
            if (r.write) m_mem[idx] = w;
            else exp.rdata = w;
        end else if (r.addr[31:28] == REGION_LED) begin
            if (r.addr[27:0] != 28'd0) exp.resp = RESP_SLVERR;
            else if (!r.write) exp.rdata = {24'd0, m_led};
            else if (r.strb[0]) m_led = r.wdata[7:0];
        end else begin
            exp.resp = RESP_DECERR;
        end
        m_txn  = m_txn + 8'd1;
        m_err  = (exp.resp != RESP_OKAY) ? m_err + 8'd1 : m_err;
        m_last = exp.resp;
    endfunction

    function automatic logic [7:0] page_value(input page_t p);
        case (p)
            2'd0:    return m_led;
            2'd1:    return m_txn;
            2'd2:    return m_err;
            default: return {6'd0, m_last};
        endcase
    endfunction

    task automatic check_rsp(input bus_rsp_t exp, input bus_rsp_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: rsp expected rdata %h resp %0d, got rdata %h resp %0d",
                     $time, exp.rdata, exp.resp, got.rdata, got.resp);
        end
    endtask

    task automatic check_leds(input logic [7:0] exp8, input logic [3:0] exp4);
        checks++;
        if (led8 !== exp8 || led4 !== exp4) begin
            errors++;
            $display("** Error at %0t ns: led8 expected %h got %h, led4 expected %b got %b",
                     $time, exp8, led8, exp4, led4);
        end
    endtask

    task automatic run_txn(input bus_req_t r, input logic heavy);
        bus_rsp_t exp;
        bus_rsp_t got;
        logic     taken;
        model_access(r, exp);
        @(posedge clk);
        req       <= r;
        req_valid <= 1'b1;
        do @(negedge clk); while (!req_ready);
        @(posedge clk); // accept edge
        req_valid <= 1'b0;
        taken = 1'b0;
        while (!taken) begin
            rsp_ready <= heavy ? (rand_bits(2) == 0) : (rand_bits(2) != 0);
            @(negedge clk);
            if (rsp_valid && rsp_ready) begin
                got   = rsp;
                taken = 1'b1;
            end
            @(posedge clk);
        end
        rsp_ready <= 1'b0;
        check_rsp(exp, got);
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    initial begin
        bus_req_t   r;
        bus_req_t   fill;
        logic [1:0] k;
        region_t    reg_n;
        int         c0;
        int         e0;
        rst_n     = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        btn       = 2'b00;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        c0 = checks;
        e0 = errors;
        check_leds(~page_value(m_page), 4'b0001 << m_page);
        report_test("reset", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_WR; i++) begin
            r = rand_req(REGION_MEM, 1'b1);
            if (!m_mem.exists(int'(r.addr[31:2] % MEM_WORDS))) begin
                fill       = r; // fresh word gets every byte first
                fill.wdata = ~r.wdata;
                fill.strb  = 4'hf;
                run_txn(fill, 1'b0);
            end
            wr_addrs.push_back(r.addr);
            run_txn(r, 1'b0);
        end
        foreach (wr_addrs[i]) begin
            r      = rand_req(REGION_MEM, 1'b0);
            r.addr = wr_addrs[i];
            run_txn(r, 1'b0);
        end
        for (int i = 0; i < N_ALIAS; i++) begin
            r            = rand_req(REGION_MEM, 1'b0);
            r.addr       = wr_addrs[rand_bits(8) % wr_addrs.size()];
            r.addr[27:0] = r.addr[27:0] + 28'(MEM_WORDS * 4 * (i + 1)); // same word at another alias
            run_txn(r, 1'b0);
        end
        report_test("memory read/write", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_LED; i++) begin
            k = 2'(rand_bits(2));
            r = rand_req(REGION_LED, k[0]);
            if (!k[1]) r.addr[27:0] = 28'd0;
            else if (r.addr[27:0] == 28'd0) r.addr[27:0] = 28'h4;
            run_txn(r, 1'b0);
        end
        report_test("led register", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_DEC; i++) begin
            reg_n = region_t'(rand_bits(4));
            if (reg_n == REGION_MEM || reg_n == REGION_LED) reg_n = reg_n + 4'd1;
            run_txn(rand_req(reg_n, 1'(rand_bits(1))), 1'b0);
        end
        report_test("decode error", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_MIX; i++) begin
            k = 2'(rand_bits(2));
            r = rand_req((k == 2'd2) ? REGION_LED : ((k == 2'd3) ? 4'd3 : REGION_MEM), !k[0]);
            if (k < 2'd2) r.addr = wr_addrs[rand_bits(8) % wr_addrs.size()];
            if (k == 2'd2) r.addr[27:0] = 28'd0;
            run_txn(r, 1'b1); // mostly stalled
        end
        report_test("back-pressure", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_BTN; i++) begin
            k = 2'(rand_bits(1));
            @(posedge clk);
            btn    <= k[0] ? 2'b10 : 2'b01;
            m_page = k[0] ? m_page - 2'd1 : m_page + 2'd1;
            repeat (2) @(posedge clk);
            btn <= 2'b00;
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_leds(~page_value(m_page), 4'b0001 << m_page);
        end
        report_test("button paging", c0, e0);

        $display("summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                 axi_sys_top_i.u_bus_ctrl.bus_ctrl_asserts_i.fail_count);
        if (errors == 0 && axi_sys_top_i.u_bus_ctrl.bus_ctrl_asserts_i.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_axi_sys_top_asserts.sv
`timescale 1ns/1ps

module tb_axi_sys_top_asserts (
    input logic              clk,
    input logic              rst_n,
    input axi_pkg::bus_rsp_t rsp,
    input logic              rsp_valid,
    input logic              rsp_ready,
    input logic              req_valid,
    input logic              req_ready
);

    int fail_count = 0; // read by the testbench summary

    // a stalled response must not move
    hold_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
        $error("rsp or rsp_valid changed under back-pressure");
        fail_count++;
    end

    // req_ready drops at accept and returns only after the response transfers
    single_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && req_ready) || (!req_ready && !(rsp_valid && rsp_ready)) |=> !req_ready)
    else begin
        $error("req_ready high while a transaction is in flight");
        fail_count++;
    end

    no_exokay: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> rsp.resp != 2'b01) // exclusive okay is never produced
    else begin
        $error("response code 1 seen on rsp");
        fail_count++;
    end

endmodule

//--- source/axi_sys_top.sv
`timescale 1ns/1ps

module axi_sys_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  axi_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    output axi_pkg::bus_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    input  logic [1:0]        btn,
    output logic [7:0]        led8,
    output logic [3:0]        led4
);
    import axi_pkg::*;

    bus_req_t   slv_req;
    logic       mem_sel;
    logic       led_sel;
    logic       mem_done;
    logic       led_done;
    bus_rsp_t   mem_rsp;
    bus_rsp_t   led_rsp;
    logic       txn_done;
    resp_t      txn_resp;
    logic [7:0] led_value;

    bus_ctrl u_bus_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .slv_req   (slv_req),
        .mem_sel   (mem_sel),
        .led_sel   (led_sel),
        .mem_done  (mem_done),
        .led_done  (led_done),
        .mem_rsp   (mem_rsp),
        .led_rsp   (led_rsp),
        .txn_done  (txn_done),
        .txn_resp  (txn_resp)
    );

    // region 0
    mem_slave #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (mem_sel),
        .slv_req (slv_req),
        .done    (mem_done),
        .slv_rsp (mem_rsp)
    );

    // region 2
    led_slave u_led_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (led_sel),
        .slv_req   (slv_req),
        .done      (led_done),
        .slv_rsp   (led_rsp),
        .led_value (led_value)
    );

    status_display u_status_display (
        .clk       (clk),
        .rst_n     (rst_n),
        .txn_done  (txn_done),
        .txn_resp  (txn_resp),
        .led_value (led_value),
        .btn       (btn),
        .led8      (led8),
        .led4      (led4)
    );

endmodule

//--- source/status_display.sv
`timescale 1ns/1ps

module status_display (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           txn_done,
    input  axi_pkg::resp_t txn_resp,
    input  logic [7:0]     led_value,
    input  logic [1:0]     btn,
    output logic [7:0]     led8,
    output logic [3:0]     led4
);
    import axi_pkg::*;

    logic [7:0] txn_cnt;
    logic [7:0] err_cnt;
    resp_t      last_resp;
    page_t      page;
    logic [1:0] btn_q;
    logic [1:0] btn_rise;
    logic       is_err;
    logic [7:0] page_val;
    logic [7:0] shown_val;
    page_t      shown_page;

    assign btn_rise = btn & ~btn_q;
    assign is_err   = (txn_resp == RESP_SLVERR) || (txn_resp == RESP_DECERR);

    // wrapping event counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            txn_cnt   <= 8'd0;
            err_cnt   <= 8'd0;
            last_resp <= RESP_OKAY;
        end else if (txn_done) begin
            txn_cnt   <= txn_cnt + 8'd1;
            last_resp <= txn_resp;
            if (is_err) begin
                err_cnt <= err_cnt + 8'd1;
            end
        end
    end

    // btn[0] pages up, btn[1] pages down
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_q <= 2'b00;
            page  <= '0;
        end else begin
            btn_q <= btn;
            case (btn_rise)
                2'b01:   page <= page + 2'd1;
                2'b10:   page <= page - 2'd1;
                default: page <= page; // both at once cancel out
            endcase
        end
    end

    always_comb begin
        case (page)
            2'd0:    page_val = led_value;
            2'd1:    page_val = txn_cnt;
            2'd2:    page_val = err_cnt;
            default: page_val = {6'd0, last_resp};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shown_val  <= 8'd0;
            shown_page <= '0;
        end else begin
            shown_val  <= page_val;
            shown_page <= page;
        end
    end

    assign led8 = ~shown_val; // leds are active low
    assign led4 = 4'b0001 << shown_page;

endmodule

//--- source/led_slave.sv
`timescale 1ns/1ps

module led_slave (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sel,
    input  axi_pkg::bus_req_t slv_req,
    output logic              done,
    output axi_pkg::bus_rsp_t slv_rsp,
    output logic [7:0]        led_value
);
    import axi_pkg::*;

    logic [7:0] led_q;
    logic       offset_ok;

    // only offset 0 of the region is mapped
    assign offset_ok = (slv_req.addr[27:0] == 28'd0);
    assign led_value = led_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led_q <= 8'd0;
            done  <= 1'b0;
        end else begin
            done <= sel;
            if (sel && offset_ok && slv_req.write && slv_req.strb[0]) begin
                led_q <= slv_req.wdata[7:0]; // low byte lane only
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            slv_rsp.resp  <= offset_ok ? RESP_OKAY : RESP_SLVERR;
            slv_rsp.rdata <= (offset_ok && !slv_req.write) ? {24'd0, led_q} : '0;
        end
    end

endmodule

//--- source/mem_slave.sv
`timescale 1ns/1ps

module mem_slave #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sel,
    input  axi_pkg::bus_req_t slv_req,
    output logic              done,
    output axi_pkg::bus_rsp_t slv_rsp
);
    import axi_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    data_t            mem [MEM_WORDS];
    logic [29:0]      word_addr;
    logic [IDX_W-1:0] idx;

    assign word_addr = slv_req.addr[31:2];
    assign idx       = IDX_W'(word_addr % MEM_WORDS); // wraps over the region

    // byte-strobe write
    always_ff @(posedge clk) begin
        if (sel && slv_req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (slv_req.strb[b]) begin
                    mem[idx][8*b +: 8] <= slv_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            slv_rsp.resp  <= RESP_OKAY;
            slv_rsp.rdata <= slv_req.write ? '0 : mem[idx]; // writes return zero
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= sel; // fixed one-cycle latency
        end
    end

endmodule

//--- source/bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  axi_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    output axi_pkg::bus_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output axi_pkg::bus_req_t slv_req,
    output logic              mem_sel,
    output logic              led_sel,
    input  logic              mem_done,
    input  logic              led_done,
    input  axi_pkg::bus_rsp_t mem_rsp,
    input  axi_pkg::bus_rsp_t led_rsp,
    output logic              txn_done,
    output axi_pkg::resp_t    txn_resp
);
    import axi_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } state_t;

    state_t   state;
    bus_req_t req_q;
    bus_rsp_t rsp_q;
    region_t  region;
    logic     accept;
    logic     rsp_fire;

    assign region   = req.addr[31:28]; // decoded straight from the incoming request
    assign accept   = req_valid && req_ready;
    assign rsp_fire = rsp_valid && rsp_ready;

    // one transaction in flight
    assign req_ready = (state == IDLE);
    assign rsp_valid = (state == RESPOND);
    assign rsp       = rsp_q;
    assign slv_req   = req_q;

    // completion report for the status display
    assign txn_done = rsp_fire;
    assign txn_resp = rsp_q.resp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            mem_sel <= 1'b0;
            led_sel <= 1'b0;
        end else begin
            mem_sel <= 1'b0; // select is a single pulse
            led_sel <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        if (region == REGION_MEM) begin
                            mem_sel <= 1'b1;
                            state   <= ACCESS;
                        end else if (region == REGION_LED) begin
                            led_sel <= 1'b1;
                            state   <= ACCESS;
                        end else begin
                            state <= RESPOND; // unmapped region answers without a slave
                        end
                    end
                end
                ACCESS: begin
                    // slaves answer one cycle after select
                    if (mem_done || led_done) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (rsp_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q         <= req;
            rsp_q.rdata   <= '0;          // decode error default
            rsp_q.resp    <= RESP_DECERR; // replaced if a slave answers
        end else if (mem_done) begin
            rsp_q <= mem_rsp;
        end else if (led_done) begin
            rsp_q <= led_rsp;
        end
    end

endmodule

//--- source/axi_pkg.sv
package axi_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;   // one bit per data byte
    typedef logic [1:0]  resp_t;
    typedef logic [3:0]  region_t; // addr[31:28]
    typedef logic [1:0]  page_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;
    localparam resp_t RESP_DECERR = 2'd3;

    // each region spans 256 MB from its start address
    localparam region_t REGION_MEM = 4'd0; // 32'h0000_0000
    localparam region_t REGION_LED = 4'd2; // 32'h2000_0000

    // single-beat request used for reads and writes
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
        strb_t strb;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        resp_t resp;
    } bus_rsp_t;

endpackage
